/* verilog/dp_cfg_pkg.sv */
`default_nettype none

package dp_cfg_pkg;

    // ------------------------------
    // Widths with a meaning
    // ------------------------------

    typedef logic [15:0] word_t;        // ALU and memory data word
    typedef logic [9:0]  d_addr_t;      // Destination (write-back) address
    typedef logic [8:0]  op_addr_t;     // A or B operand read address
    typedef logic [7:0]  ram_addr_t;    // Local index into one RAM

    // ------------------------------
    // Memory map
    // ------------------------------

    localparam int       RAM_DEPTH       = 256;
    localparam op_addr_t IO_READ_ADDR    = op_addr_t'(256);     // Operand value selecting io_in

    // Each memory owns a 512-entry slice of the D space
    localparam d_addr_t  A_WRITE_BASE    = d_addr_t'(0);
    localparam d_addr_t  B_WRITE_BASE    = d_addr_t'(512);
    localparam d_addr_t  IO_WRITE_OFFSET = d_addr_t'(256);      // Offset of io_out in a slice

    localparam d_addr_t  D_NULL          = d_addr_t'(1023);     // Hits neither slice

    // Issue to alu_result, in cycles
    localparam int       PIPE_DEPTH      = 2;

endpackage

`default_nettype wire

/* verilog/dp_isa_pkg.sv */
`default_nettype none

package dp_isa_pkg;

    localparam int INSTR_WIDTH = 32;
    localparam int OP_WIDTH    = 4;

    typedef logic [INSTR_WIDTH-1:0] instr_t;

    // ------------------------------
    // Field positions, LSB of each
    // ------------------------------

    localparam int OP_LSB = 28;     // Bits 31..28
    localparam int D_LSB  = 18;     // Bits 27..18
    localparam int A_LSB  = 9;      // Bits 17..9
    localparam int B_LSB  = 0;      // Bits 8..0

    // ------------------------------
    // Opcodes
    // ------------------------------

    typedef enum logic [OP_WIDTH-1:0] {
        NOP    = 4'd0,              // Result is zero
        ADD    = 4'd1,
        SUB    = 4'd2,
        AND    = 4'd3,
        OR     = 4'd4,
        XOR    = 4'd5,
        PASS_A = 4'd6,
        SHR    = 4'd7               // A >> B[3:0], zero fill
    } op_t;

endpackage

`default_nettype wire

/* verilog/delay_line.sv */
`timescale 1ns/10ps
`default_nettype none

module delay_line #(
    parameter int               DEPTH       = 1,
    parameter int               WIDTH       = 1,
    parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
    input  wire              clock,
    input  wire              rst_n,
    input  wire  [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] stage [DEPTH];    // stage[0] is loaded from din

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= RESET_VALUE;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];     // Shift toward the output
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

/* verilog/operand_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_memory #(
    parameter dp_cfg_pkg::d_addr_t WRITE_BASE = dp_cfg_pkg::A_WRITE_BASE
) (
    input  wire                        clock,
    input  wire                        rst_n,

    // Issue side
    input  wire  dp_cfg_pkg::op_addr_t rd_addr,
    input  wire                        io_ready,
    input  wire  dp_cfg_pkg::d_addr_t  d_issue,
    output dp_cfg_pkg::word_t          rd_data,
    output logic                       read_blocked,
    output logic                       write_blocked,

    // Write-back side
    input  wire  dp_cfg_pkg::d_addr_t  wr_d,
    input  wire  dp_cfg_pkg::word_t    wr_data,

    // Memory-mapped ports
    input  wire  dp_cfg_pkg::word_t    io_in,
    input  wire                        io_in_ef,
    input  wire                        io_out_ef,
    output logic                       io_rden,
    output logic                       io_wren,
    output dp_cfg_pkg::word_t          io_out
);

    dp_cfg_pkg::word_t     ram [dp_cfg_pkg::RAM_DEPTH];

    logic                  rd_port_sel;
    dp_cfg_pkg::ram_addr_t rd_idx;
    dp_cfg_pkg::d_addr_t   issue_off;
    dp_cfg_pkg::d_addr_t   wr_off;
    logic                  wr_ram_hit;
    dp_cfg_pkg::ram_addr_t wr_idx;

// ------------------------------
// Issue cycle: flags and read
// ------------------------------

    assign rd_port_sel = (rd_addr == dp_cfg_pkg::IO_READ_ADDR);
    assign rd_idx      = dp_cfg_pkg::ram_addr_t'(rd_addr);

    // Offset of the issuing D inside this memory's slice
    assign issue_off   = d_issue - WRITE_BASE;

    // Masked flags, only raised when this instruction touches the port
    assign read_blocked  = rd_port_sel & io_in_ef;
    assign write_blocked = (issue_off == dp_cfg_pkg::IO_WRITE_OFFSET) & io_out_ef;

    assign io_rden = rd_port_sel & io_ready;    // Pop happens at this edge

    always_ff @(posedge clock) begin
        if (rd_port_sel) begin
            rd_data <= io_in;       // Port word, same timing as RAM
        end else begin
            rd_data <= ram[rd_idx];
        end
    end

// ------------------------------
// Write-back decode
// ------------------------------

    // Slices are 512 aligned, so a wrapped subtract gives the local offset
    assign wr_off     = wr_d - WRITE_BASE;
    assign wr_ram_hit = (wr_off < dp_cfg_pkg::d_addr_t'(dp_cfg_pkg::RAM_DEPTH));
    assign wr_idx     = dp_cfg_pkg::ram_addr_t'(wr_off);

    assign io_wren = (wr_off == dp_cfg_pkg::IO_WRITE_OFFSET);
    assign io_out  = wr_data;

    always_ff @(posedge clock) begin
        if (wr_ram_hit) begin
            ram[wr_idx] <= wr_data;
        end
    end

// ------------------------------
// Checks
// ------------------------------

    // The top must hold io_ready low whenever this port is empty
    rden_not_empty: assert property (
        @(posedge clock) disable iff (!rst_n)
        io_rden |-> !io_in_ef
    ) else $error("io_rden while input port empty");

    // Full is sampled at issue, the sink must not fill while a write is in flight
    wren_not_full: assert property (
        @(posedge clock) disable iff (!rst_n)
        io_wren |-> !io_out_ef
    ) else $error("io_wren while output port full");

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire  dp_isa_pkg::op_t     op,       // Issue cycle opcode
    input  wire  dp_cfg_pkg::word_t   a,        // Registered operands, cycle t+1
    input  wire  dp_cfg_pkg::word_t   b,
    input  wire  dp_cfg_pkg::d_addr_t d_in,
    output dp_cfg_pkg::word_t         result,
    output dp_cfg_pkg::d_addr_t       d_out
);

    dp_isa_pkg::op_t   op_q;
    dp_cfg_pkg::word_t alu_value;

    // Opcode waits one cycle for the operand reads
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= dp_isa_pkg::NOP;
        end else begin
            op_q <= op;
        end
    end

    always_comb begin
        case (op_q)
            dp_isa_pkg::ADD:    alu_value = a + b;
            dp_isa_pkg::SUB:    alu_value = a - b;
            dp_isa_pkg::AND:    alu_value = a & b;
            dp_isa_pkg::OR:     alu_value = a | b;
            dp_isa_pkg::XOR:    alu_value = a ^ b;
            dp_isa_pkg::PASS_A: alu_value = a;
            dp_isa_pkg::SHR:    alu_value = a >> b[3:0];   // Logical, zero fill
            default:            alu_value = '0;             // NOP
        endcase
    end

// ------------------------------
// Output stage
// ------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            d_out  <= dp_cfg_pkg::D_NULL;
        end else begin
            result <= alu_value;
            d_out  <= d_in;     // Travels with its result
        end
    end

    // Decoded opcode from the top must be one of the defined values
    op_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        !$isunknown(op) && (op <= dp_isa_pkg::SHR)
    ) else $error("undefined opcode %0d at issue", op);

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath (
    input  wire                        clock,
    input  wire                        rst_n,
    input  wire  dp_isa_pkg::instr_t   instr,
    input  wire                        cancel,

    input  wire  dp_cfg_pkg::word_t    a_io_in,
    input  wire                        a_io_in_ef,
    input  wire                        a_io_out_ef,
    output logic                       a_io_rden,
    output logic                       a_io_wren,
    output dp_cfg_pkg::word_t          a_io_out,

    input  wire  dp_cfg_pkg::word_t    b_io_in,
    input  wire                        b_io_in_ef,
    input  wire                        b_io_out_ef,
    output logic                       b_io_rden,
    output logic                       b_io_wren,
    output dp_cfg_pkg::word_t          b_io_out,

    output dp_cfg_pkg::word_t          alu_result,
    output dp_cfg_pkg::d_addr_t        alu_d,
    output logic                       io_ready
);

    dp_isa_pkg::op_t      op_issue;
    dp_cfg_pkg::d_addr_t  d_issue;
    dp_cfg_pkg::op_addr_t a_addr;
    dp_cfg_pkg::op_addr_t b_addr;

    dp_cfg_pkg::d_addr_t  d_masked;
    dp_cfg_pkg::d_addr_t  d_alu_in;
    dp_cfg_pkg::word_t    a_rd_data;
    dp_cfg_pkg::word_t    b_rd_data;

    logic a_read_blocked;
    logic a_write_blocked;
    logic b_read_blocked;
    logic b_write_blocked;

// ------------------------------
// Field decode
// ------------------------------

    assign op_issue = dp_isa_pkg::op_t'(instr[dp_isa_pkg::OP_LSB +: dp_isa_pkg::OP_WIDTH]);
    assign d_issue  = instr[dp_isa_pkg::D_LSB +: $bits(dp_cfg_pkg::d_addr_t)];
    assign a_addr   = instr[dp_isa_pkg::A_LSB +: $bits(dp_cfg_pkg::op_addr_t)];
    assign b_addr   = instr[dp_isa_pkg::B_LSB +: $bits(dp_cfg_pkg::op_addr_t)];

// ------------------------------
// Ready, cancel and annulment
// ------------------------------

    assign io_ready = ~(a_read_blocked | a_write_blocked |
                        b_read_blocked | b_write_blocked) & ~cancel;

    // An annulled instruction still runs the ALU but writes nowhere
    assign d_masked = io_ready ? d_issue : dp_cfg_pkg::D_NULL;

    delay_line #(
        .DEPTH       (dp_cfg_pkg::PIPE_DEPTH - 1),  // Read stage only, ALU adds the last
        .WIDTH       ($bits(dp_cfg_pkg::d_addr_t)),
        .RESET_VALUE (dp_cfg_pkg::D_NULL)
    ) d_pipe0 (
        .clock (clock),
        .rst_n (rst_n),
        .din   (d_masked),
        .dout  (d_alu_in)
    );

// ------------------------------
// Operand memories
// ------------------------------

    operand_memory #(
        .WRITE_BASE (dp_cfg_pkg::A_WRITE_BASE)
    ) mem_a0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .rd_addr       (a_addr),
        .io_ready      (io_ready),
        .d_issue       (d_issue),
        .rd_data       (a_rd_data),
        .read_blocked  (a_read_blocked),
        .write_blocked (a_write_blocked),
        .wr_d          (alu_d),
        .wr_data       (alu_result),
        .io_in         (a_io_in),
        .io_in_ef      (a_io_in_ef),
        .io_out_ef     (a_io_out_ef),
        .io_rden       (a_io_rden),
        .io_wren       (a_io_wren),
        .io_out        (a_io_out)
    );

    operand_memory #(
        .WRITE_BASE (dp_cfg_pkg::B_WRITE_BASE)
    ) mem_b0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .rd_addr       (b_addr),
        .io_ready      (io_ready),
        .d_issue       (d_issue),
        .rd_data       (b_rd_data),
        .read_blocked  (b_read_blocked),
        .write_blocked (b_write_blocked),
        .wr_d          (alu_d),
        .wr_data       (alu_result),
        .io_in         (b_io_in),
        .io_in_ef      (b_io_in_ef),
        .io_out_ef     (b_io_out_ef),
        .io_rden       (b_io_rden),
        .io_wren       (b_io_wren),
        .io_out        (b_io_out)
    );

    alu alu0 (
        .clock  (clock),
        .rst_n  (rst_n),
        .op     (op_issue),
        .a      (a_rd_data),
        .b      (b_rd_data),
        .d_in   (d_alu_in),
        .result (alu_result),
        .d_out  (alu_d)
    );

endmodule

`default_nettype wire

/* dv/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Write-back waiting to become visible
typedef struct {
    int                  cyc;       // Issue cycle of the writer
    dp_cfg_pkg::d_addr_t d;
    dp_cfg_pkg::word_t   val;
} wb_t;

dp_cfg_pkg::word_t shadow_a [dp_cfg_pkg::RAM_DEPTH];
dp_cfg_pkg::word_t shadow_b [dp_cfg_pkg::RAM_DEPTH];
wb_t               wb_q [$];

function automatic dp_cfg_pkg::word_t alu_ref(input dp_isa_pkg::op_t op,
                                              input dp_cfg_pkg::word_t a,
                                              input dp_cfg_pkg::word_t b);
    case (op)
        dp_isa_pkg::ADD:    return a + b;
        dp_isa_pkg::SUB:    return a - b;
        dp_isa_pkg::AND:    return a & b;
        dp_isa_pkg::OR:     return a | b;
        dp_isa_pkg::XOR:    return a ^ b;
        dp_isa_pkg::PASS_A: return a;
        dp_isa_pkg::SHR:    return a >> b[3:0];    // Zero fill
        default:            return '0;
    endcase
endfunction

function automatic void post_write(input int cyc, input dp_cfg_pkg::d_addr_t d,
                                   input dp_cfg_pkg::word_t val);
    wb_t w;
    w.cyc = cyc;
    w.d   = d;
    w.val = val;
    wb_q.push_back(w);
endfunction

// A write issued at t is seen by the issue at t+3
function automatic void retire_writes(input int now);
    wb_t w;
    while (wb_q.size() > 0 && wb_q[0].cyc + 3 <= now) begin
        w = wb_q.pop_front();
        if (w.d < dp_cfg_pkg::d_addr_t'(dp_cfg_pkg::RAM_DEPTH)) begin
            shadow_a[dp_cfg_pkg::ram_addr_t'(w.d)] = w.val;
        end else if (w.d >= dp_cfg_pkg::B_WRITE_BASE &&
                     w.d < dp_cfg_pkg::B_WRITE_BASE + dp_cfg_pkg::RAM_DEPTH) begin
            shadow_b[dp_cfg_pkg::ram_addr_t'(w.d - dp_cfg_pkg::B_WRITE_BASE)] = w.val;
        end
    end
endfunction

`endif

/* dv/tb_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_datapath;

    `include "tb_model.svh"

    localparam dp_cfg_pkg::d_addr_t A_OUT_D = dp_cfg_pkg::A_WRITE_BASE +
                                              dp_cfg_pkg::IO_WRITE_OFFSET;
    localparam dp_cfg_pkg::d_addr_t B_OUT_D = dp_cfg_pkg::B_WRITE_BASE +
                                              dp_cfg_pkg::IO_WRITE_OFFSET;

    typedef struct {
        int                  cyc;
        logic                ready;
        logic                rden_a;
        logic                rden_b;
        dp_cfg_pkg::word_t   res;
        dp_cfg_pkg::d_addr_t d;
        logic                wren_a;
        logic                wren_b;
    } pred_t;

    logic clock;
    logic rst_n;
    dp_isa_pkg::instr_t instr;
    logic cancel;
    dp_cfg_pkg::word_t a_io_in, b_io_in, a_io_out, b_io_out, alu_result;
    logic a_io_in_ef, a_io_out_ef, a_io_rden, a_io_wren;
    logic b_io_in_ef, b_io_out_ef, b_io_rden, b_io_wren;
    dp_cfg_pkg::d_addr_t alu_d;
    logic io_ready;

    // Port models
    dp_cfg_pkg::word_t a_in_q [$];
    dp_cfg_pkg::word_t b_in_q [$];
    dp_cfg_pkg::word_t a_sink_q [$];
    dp_cfg_pkg::word_t b_sink_q [$];
    logic a_hold_empty, b_hold_empty, a_out_full, b_out_full;
    logic a_pop_pend, b_pop_pend;
    int   exp_a_wr, exp_b_wr;
    int   cycle_cnt;

    pred_t exp_q [$];
    pred_t now_p;
    pred_t done_p;

    always #4 clock = ~clock;

    datapath dut0 (
        .clock (clock), .rst_n (rst_n), .instr (instr), .cancel (cancel),
        .a_io_in (a_io_in), .a_io_in_ef (a_io_in_ef), .a_io_out_ef (a_io_out_ef),
        .a_io_rden (a_io_rden), .a_io_wren (a_io_wren), .a_io_out (a_io_out),
        .b_io_in (b_io_in), .b_io_in_ef (b_io_in_ef), .b_io_out_ef (b_io_out_ef),
        .b_io_rden (b_io_rden), .b_io_wren (b_io_wren), .b_io_out (b_io_out),
        .alu_result (alu_result), .alu_d (alu_d), .io_ready (io_ready)
    );

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    function automatic dp_isa_pkg::instr_t make_instr(input dp_isa_pkg::op_t op,
            input dp_cfg_pkg::d_addr_t d, input dp_cfg_pkg::op_addr_t a,
            input dp_cfg_pkg::op_addr_t b);
        return {op, d, a, b};
    endfunction

    // Input ports pop on the edge that sees rden
    always @(posedge clock) begin
        a_pop_pend <= a_io_rden;
        b_pop_pend <= b_io_rden;
    end

    // Output sinks take a word in every cycle that shows wren
    always @(negedge clock) begin
        if (rst_n) begin
            if (a_io_wren) begin
                a_sink_q.push_back(a_io_out);
            end
            if (b_io_wren) begin
                b_sink_q.push_back(b_io_out);
            end
        end
    end

// ------------------------------
// Comparison process
// ------------------------------

    always @(negedge clock) begin
        if (rst_n && exp_q.size() > 0) begin
            now_p = exp_q[$];
            if (now_p.cyc == cycle_cnt) begin               // Issue side checks in this cycle
                check_eq("io_ready", 32'(io_ready), 32'(now_p.ready));
                check_eq("a_io_rden", 32'(a_io_rden), 32'(now_p.rden_a));
                check_eq("b_io_rden", 32'(b_io_rden), 32'(now_p.rden_b));
            end
            if (exp_q[0].cyc + dp_cfg_pkg::PIPE_DEPTH == cycle_cnt) begin
                done_p = exp_q.pop_front();
                check_eq("alu_result", 32'(alu_result), 32'(done_p.res));
                check_eq("alu_d", 32'(alu_d), 32'(done_p.d));
                check_eq("a_io_wren", 32'(a_io_wren), 32'(done_p.wren_a));
                check_eq("b_io_wren", 32'(b_io_wren), 32'(done_p.wren_b));
                if (a_io_wren) begin
                    check_eq("a_io_out", 32'(a_io_out), 32'(done_p.res));
                end
                if (b_io_wren) begin
                    check_eq("b_io_out", 32'(b_io_out), 32'(done_p.res));
                end
            end
        end
    end

// ------------------------------
// Stimulus tasks
// ------------------------------

    task automatic advance();
        @(posedge clock);
        #1;
        if (a_pop_pend) begin
            void'(a_in_q.pop_front());
        end
        if (b_pop_pend) begin
            void'(b_in_q.pop_front());
        end
        cycle_cnt++;
        retire_writes(cycle_cnt);
        a_io_in     = (a_in_q.size() > 0) ? a_in_q[0] : '0;
        a_io_in_ef  = (a_in_q.size() == 0) || a_hold_empty;
        a_io_out_ef = a_out_full;
        b_io_in     = (b_in_q.size() > 0) ? b_in_q[0] : '0;
        b_io_in_ef  = (b_in_q.size() == 0) || b_hold_empty;
        b_io_out_ef = b_out_full;
    endtask

    task automatic idle();
        advance();
        instr  = make_instr(dp_isa_pkg::NOP, dp_cfg_pkg::D_NULL, '0, '0);
        cancel = 1'b0;
    endtask

    task automatic issue(input dp_isa_pkg::op_t op, input dp_cfg_pkg::d_addr_t d,
                         input dp_cfg_pkg::op_addr_t a, input dp_cfg_pkg::op_addr_t b,
                         input logic cncl, output logic accepted);
        pred_t             p;
        dp_cfg_pkg::word_t a_val;
        dp_cfg_pkg::word_t b_val;
        logic              a_sel;
        logic              b_sel;
        advance();
        a_sel    = (a == dp_cfg_pkg::IO_READ_ADDR);
        b_sel    = (b == dp_cfg_pkg::IO_READ_ADDR);
        a_val    = a_sel ? a_io_in : shadow_a[dp_cfg_pkg::ram_addr_t'(a)];
        b_val    = b_sel ? b_io_in : shadow_b[dp_cfg_pkg::ram_addr_t'(b)];
        p.cyc    = cycle_cnt;
        p.ready  = !((a_sel && a_io_in_ef) || (b_sel && b_io_in_ef) || cncl ||
                     (d == A_OUT_D && a_out_full) || (d == B_OUT_D && b_out_full));
        p.rden_a = a_sel && p.ready;
        p.rden_b = b_sel && p.ready;
        p.res    = alu_ref(op, a_val, b_val);
        p.d      = p.ready ? d : dp_cfg_pkg::D_NULL;    // Annulled writes go nowhere
        p.wren_a = (p.d == A_OUT_D);
        p.wren_b = (p.d == B_OUT_D);
        exp_a_wr += int'(p.wren_a);
        exp_b_wr += int'(p.wren_b);
        post_write(cycle_cnt, p.d, p.res);
        exp_q.push_back(p);
        instr    = make_instr(op, d, a, b);
        cancel   = cncl;
        accepted = p.ready;
    endtask

    // Source side retry while the input ports flicker between ready and empty
    task automatic issue_until_accepted(input dp_isa_pkg::op_t op,
            input dp_cfg_pkg::d_addr_t d, input dp_cfg_pkg::op_addr_t a,
            input dp_cfg_pkg::op_addr_t b);
        logic ok;
        int   tries;
        ok    = 1'b0;
        tries = 0;
        while (!ok && tries < 16) begin
            a_hold_empty = ($urandom % 4 == 0);
            b_hold_empty = ($urandom % 4 == 0);
            issue(op, d, a, b, 1'b0, ok);
            tries++;
        end
        a_hold_empty = 1'b0;
        b_hold_empty = 1'b0;
        if (!ok) begin
            abort_run("instruction not accepted within 16 tries");
        end
    endtask

// ------------------------------
// Test sequence
// ------------------------------

    initial begin
        dp_isa_pkg::op_t     rand_ops [7];
        dp_isa_pkg::op_t     op_r;
        dp_cfg_pkg::d_addr_t d_r;
        logic                ok;
        int                  pick;
        int                  wait_cnt;

        void'($urandom(32'h7b5fc382));
        rand_ops = '{dp_isa_pkg::NOP, dp_isa_pkg::ADD, dp_isa_pkg::SUB, dp_isa_pkg::AND,
                     dp_isa_pkg::OR, dp_isa_pkg::XOR, dp_isa_pkg::SHR};
        clock = 1'b0;
        rst_n = 1'b0;
        instr = make_instr(dp_isa_pkg::NOP, dp_cfg_pkg::D_NULL, '0, '0);
        cancel = 1'b0;
        a_io_in = '0;
        a_io_in_ef = 1'b1;
        a_io_out_ef = 1'b0;
        b_io_in = '0;
        b_io_in_ef = 1'b1;
        b_io_out_ef = 1'b0;
        a_hold_empty = 1'b0;
        b_hold_empty = 1'b0;
        a_out_full = 1'b0;
        b_out_full = 1'b0;
        cycle_cnt = 0;
        exp_a_wr = 0;
        exp_b_wr = 0;
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;

        check_eq("a_io_rden", 32'(a_io_rden), 32'h0);
        check_eq("b_io_rden", 32'(b_io_rden), 32'h0);
        check_eq("a_io_wren", 32'(a_io_wren), 32'h0);
        check_eq("b_io_wren", 32'(b_io_wren), 32'h0);
        check_eq("alu_d", 32'(alu_d), 32'(dp_cfg_pkg::D_NULL));

        // Fill RAM A from port A, then RAM B from both ports
        for (int i = 0; i < dp_cfg_pkg::RAM_DEPTH; i++) begin
            a_in_q.push_back(dp_cfg_pkg::word_t'($urandom));
        end
        for (int i = 0; i < dp_cfg_pkg::RAM_DEPTH; i++) begin
            issue_until_accepted(dp_isa_pkg::PASS_A, dp_cfg_pkg::d_addr_t'(i),
                                 dp_cfg_pkg::IO_READ_ADDR, '0);
        end
        for (int i = 0; i < dp_cfg_pkg::RAM_DEPTH; i++) begin
            a_in_q.push_back(dp_cfg_pkg::word_t'($urandom));
            b_in_q.push_back(dp_cfg_pkg::word_t'($urandom));
        end
        for (int i = 0; i < dp_cfg_pkg::RAM_DEPTH; i++) begin
            issue_until_accepted(dp_isa_pkg::XOR,
                                 dp_cfg_pkg::B_WRITE_BASE + dp_cfg_pkg::d_addr_t'(i),
                                 dp_cfg_pkg::IO_READ_ADDR, dp_cfg_pkg::IO_READ_ADDR);
        end
        for (int i = 0; i < dp_cfg_pkg::RAM_DEPTH; i++) begin
            issue(dp_isa_pkg::XOR, dp_cfg_pkg::D_NULL, dp_cfg_pkg::op_addr_t'(i),
                  dp_cfg_pkg::op_addr_t'(i), 1'b0, ok);
        end

        // Random ALU traffic with write-back to either RAM
        for (int n = 0; n < 300; n++) begin
            op_r = rand_ops[$urandom % 7];
            pick = $urandom % 3;
            case (pick)
                0:       d_r = dp_cfg_pkg::d_addr_t'($urandom % 256);
                1:       d_r = dp_cfg_pkg::B_WRITE_BASE + dp_cfg_pkg::d_addr_t'($urandom % 256);
                default: d_r = dp_cfg_pkg::D_NULL;
            endcase
            issue(op_r, d_r, dp_cfg_pkg::op_addr_t'($urandom % 256),
                  dp_cfg_pkg::op_addr_t'($urandom % 256), 1'b0, ok);
        end

        // Empty input stalls
        issue(dp_isa_pkg::PASS_A, 10'd5, dp_cfg_pkg::IO_READ_ADDR, '0, 1'b0, ok);
        b_in_q.push_back(16'h1234);
        b_hold_empty = 1'b1;
        issue(dp_isa_pkg::ADD, B_OUT_D - 10'd1, 9'd3, dp_cfg_pkg::IO_READ_ADDR, 1'b0, ok);
        b_hold_empty = 1'b0;
        issue(dp_isa_pkg::ADD, B_OUT_D - 10'd1, 9'd3, dp_cfg_pkg::IO_READ_ADDR, 1'b0, ok);
        repeat (3) idle();
        issue(dp_isa_pkg::PASS_A, dp_cfg_pkg::D_NULL, 9'd5, '0, 1'b0, ok);

        // Output ports free and then full
        issue(dp_isa_pkg::ADD, A_OUT_D, 9'd10, 9'd20, 1'b0, ok);
        issue(dp_isa_pkg::XOR, B_OUT_D, 9'd11, 9'd21, 1'b0, ok);
        repeat (3) idle();
        a_out_full = 1'b1;
        b_out_full = 1'b1;
        issue(dp_isa_pkg::ADD, A_OUT_D, 9'd12, 9'd22, 1'b0, ok);
        issue(dp_isa_pkg::SUB, B_OUT_D, 9'd13, 9'd23, 1'b0, ok);
        repeat (3) idle();
        a_out_full = 1'b0;
        b_out_full = 1'b0;

        // Cancel annuls port traffic and RAM write-back
        a_in_q.push_back(dp_cfg_pkg::word_t'($urandom));
        issue(dp_isa_pkg::PASS_A, B_OUT_D, dp_cfg_pkg::IO_READ_ADDR, '0, 1'b1, ok);
        issue(dp_isa_pkg::ADD, 10'd7, 9'd1, 9'd2, 1'b1, ok);
        issue(dp_isa_pkg::PASS_A, dp_cfg_pkg::D_NULL, dp_cfg_pkg::IO_READ_ADDR, '0, 1'b0, ok);
        repeat (3) idle();
        issue(dp_isa_pkg::PASS_A, dp_cfg_pkg::D_NULL, 9'd7, '0, 1'b0, ok);

        wait_cnt = 0;
        while (exp_q.size() > 0 && wait_cnt < 10) begin
            idle();
            wait_cnt++;
        end
        if (exp_q.size() > 0) begin
            abort_run("results still pending after 10 idle cycles");
        end else begin
            check_eq("a_sink_count", 32'(a_sink_q.size()), 32'(exp_a_wr));
            check_eq("b_sink_count", 32'(b_sink_q.size()), 32'(exp_b_wr));
            check_eq("a_in_level", 32'(a_in_q.size()), 32'h0);
            check_eq("b_in_level", 32'(b_in_q.size()), 32'h0);
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+dv
verilog/dp_cfg_pkg.sv
verilog/dp_isa_pkg.sv
verilog/delay_line.sv
verilog/operand_memory.sv
verilog/alu.sv
verilog/datapath.sv
dv/tb_datapath.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_datapath
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# The pipe hides the simulator status, so the log search decides
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
